//--- csr_index_cfg_settings.svh
// CSR index configuration settings

`ifndef CSR_INDEX_CFG_SETTINGS_SVH
`define CSR_INDEX_CFG_SETTINGS_SVH

// ---------------------------------------------------------
// Frame and response word geometry
// ---------------------------------------------------------
// Words per configuration frame
`define CSR_CFG_SEQ_WIDTH 16

`define CSR_CFG_DATA_W 32
`define CSR_CFG_OFFSET_W 16

// ---------------------------------------------------------
// Output queue
// ---------------------------------------------------------
`define CSR_CFG_QUEUE_DEPTH 16

// ---------------------------------------------------------
// Field widths inside the data words
// ---------------------------------------------------------
`define CSR_CFG_CACHE_W 4
// Ops mask is this squared
`define CSR_CFG_NUM_FIELDS 4
`define CSR_CFG_GRAN_W 5

`define CSR_CFG_CHANNEL_W 2
`define CSR_CFG_BUFFER_W 3

`endif

//--- csr_index_cfg_pkg.sv
// CSR index configuration types

`default_nettype none

`include "csr_index_cfg_settings.svh"

package csr_index_cfg_pkg;

    localparam int unsigned OPS_MASK_W = `CSR_CFG_NUM_FIELDS * `CSR_CFG_NUM_FIELDS;

    // One memory response as seen after the memory port
    typedef struct packed {
        logic [`CSR_CFG_OFFSET_W-1:0] offset;
        logic [`CSR_CFG_DATA_W-1:0]   data;
    } response_word_t;

    typedef logic [`CSR_CFG_SEQ_WIDTH-1:0] slot_onehot_t;

    // Increment sits in bit 0, parallel in bit 5
    typedef struct packed {
        logic mode_parallel;
        logic mode_break;
        logic mode_buffer;
        logic mode_sequence;
        logic decrement;
        logic increment;
    } index_flags_t;

    typedef struct packed {
        index_flags_t                   flags;
        logic [`CSR_CFG_DATA_W-1:0]     index_start;
        logic [`CSR_CFG_DATA_W-1:0]     index_end;
        logic [`CSR_CFG_DATA_W-1:0]     stride;
        logic [`CSR_CFG_GRAN_W-1:0]     granularity;
        logic                           direction;
        logic [`CSR_CFG_CHANNEL_W-1:0]  id_channel;
        logic [`CSR_CFG_BUFFER_W-1:0]   id_buffer;
        logic [`CSR_CFG_DATA_W-1:0]     array_size;
        logic [`CSR_CFG_NUM_FIELDS-1:0] const_mask;
        logic [`CSR_CFG_CACHE_W-1:0]    mode_cache;
        logic [`CSR_CFG_DATA_W-1:0]     const_value;
        logic [OPS_MASK_W-1:0]          ops_mask;
    } csr_index_config_t;

    // First word offset owned by an engine
    function automatic int unsigned window_base(input int unsigned window_index);
        return window_index * `CSR_CFG_SEQ_WIDTH;
    endfunction

endpackage

`default_nettype wire

//--- csr_index_cfg_window_filter.sv
// Response window filter

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_cfg_settings.svh"

module csr_index_cfg_window_filter #(
    parameter int unsigned WINDOW_INDEX = 0
) (
    input  logic                                ap_clk,
    input  logic                                areset_csr_index_generator,
    input  logic                                response_valid,
    input  logic [`CSR_CFG_OFFSET_W-1:0]        response_offset,
    input  logic [`CSR_CFG_DATA_W-1:0]          response_data,
    output logic                                word_valid,
    output csr_index_cfg_pkg::response_word_t   word
);

    localparam int unsigned WIN_LO = csr_index_cfg_pkg::window_base(WINDOW_INDEX);
    localparam int unsigned WIN_HI = WIN_LO + `CSR_CFG_SEQ_WIDTH;

    logic                              valid_reg;
    csr_index_cfg_pkg::response_word_t word_reg;
    logic                              in_window;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            valid_reg <= 1'b0;
        end else begin
            valid_reg <= response_valid;
        end
    end

    // Payload travels without reset
    always_ff @(posedge ap_clk) begin
        word_reg.offset <= response_offset;
        word_reg.data   <= response_data;
    end

    // Base is inclusive, base plus frame width is not
    assign in_window  = (word_reg.offset >= WIN_LO) && (word_reg.offset < WIN_HI);
    assign word_valid = valid_reg & in_window;
    assign word       = word_reg;

endmodule

`default_nettype wire

//--- csr_index_cfg_word_tracker.sv
// One-hot configuration frame tracker

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_cfg_settings.svh"

module csr_index_cfg_word_tracker #(
    parameter int unsigned WINDOW_INDEX = 0
) (
    input  logic                                ap_clk,
    input  logic                                areset_csr_index_generator,
    input  logic                                word_valid,
    input  csr_index_cfg_pkg::response_word_t   word,
    output logic                                slot_valid,
    output csr_index_cfg_pkg::slot_onehot_t     slot,
    output logic [`CSR_CFG_DATA_W-1:0]          slot_data,
    output logic                                frame_done
);

    localparam int unsigned BASE = csr_index_cfg_pkg::window_base(WINDOW_INDEX);
    localparam int unsigned LAST = `CSR_CFG_SEQ_WIDTH - 1;

    csr_index_cfg_pkg::slot_onehot_t frame_reg;
    csr_index_cfg_pkg::slot_onehot_t frame_next;
    logic                            tracker_idle;
    logic                            start_frame;

    // Last slot counts as idle since the frame ends on this edge
    assign tracker_idle = (frame_reg == '0) | frame_reg[LAST];
    assign start_frame  = word_valid & (word.offset == BASE) & tracker_idle;

    // ---------------------------------------------------------
    // Start at base word, shift once per accepted word
    // ---------------------------------------------------------
    always_comb begin
        if (start_frame) begin
            frame_next = csr_index_cfg_pkg::slot_onehot_t'(1);
        end else if (word_valid) begin
            frame_next = frame_reg << 1;
        end else if (frame_reg[LAST]) begin
            frame_next = '0;
        end else begin
            frame_next = frame_reg;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            frame_reg  <= '0;
            slot_valid <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_reg  <= frame_next;
            slot_valid <= word_valid & (frame_next != '0);
            frame_done <= frame_reg[LAST];
        end
    end

    always_ff @(posedge ap_clk) begin
        slot_data <= word.data;
    end

    assign slot = frame_reg;

    a_frame_onehot : assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        $onehot0(frame_reg))
        else $error("Frame register holds more than one slot");

endmodule

`default_nettype wire

//--- csr_index_cfg_field_decoder.sv
// Configuration record field decoder

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_cfg_settings.svh"

module csr_index_cfg_field_decoder (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_index_generator,
    input  logic                                  slot_valid,
    input  csr_index_cfg_pkg::slot_onehot_t       slot,
    input  logic [`CSR_CFG_DATA_W-1:0]            slot_data,
    input  logic                                  frame_done,
    output logic                                  record_valid,
    output csr_index_cfg_pkg::csr_index_config_t  record
);

    localparam int unsigned MASK_W  = `CSR_CFG_NUM_FIELDS;
    localparam int unsigned CACHE_HI = MASK_W + `CSR_CFG_CACHE_W - 1;

    // Fields under assembly for the current frame
    csr_index_cfg_pkg::csr_index_config_t cfg_work;

    // ---------------------------------------------------------
    // Per-slot field writes
    // ---------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (slot_valid) begin
            case (1'b1)
                slot[0]: cfg_work.flags <= csr_index_cfg_pkg::index_flags_t'(slot_data[5:0]);
                slot[1]: cfg_work.index_start <= slot_data;
                slot[2]: cfg_work.index_end <= slot_data;
                slot[3]: cfg_work.stride <= slot_data;
                slot[4]: begin
                    cfg_work.granularity <= slot_data[`CSR_CFG_GRAN_W-1:0];
                    cfg_work.direction   <= slot_data[`CSR_CFG_DATA_W-1];
                end
                slot[5]: cfg_work.id_channel <= slot_data[`CSR_CFG_CHANNEL_W-1:0];
                slot[6]: cfg_work.id_buffer <= slot_data[`CSR_CFG_BUFFER_W-1:0];
                slot[7]: cfg_work.array_size <= slot_data;
                slot[8]: begin
                    cfg_work.const_mask <= slot_data[MASK_W-1:0];
                    cfg_work.mode_cache <= slot_data[CACHE_HI:MASK_W];
                end
                slot[9]: cfg_work.const_value <= slot_data;
                slot[10]: begin
                    cfg_work.ops_mask <= slot_data[csr_index_cfg_pkg::OPS_MASK_W-1:0];
                end
                // Slots 11 to 15 only advance the frame
                default: begin
                end
            endcase
        end
    end

    // Snapshot lets the next frame start writing right away
    always_ff @(posedge ap_clk) begin
        if (frame_done) begin
            record <= cfg_work;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            record_valid <= 1'b0;
        end else begin
            record_valid <= frame_done;
        end
    end

endmodule

`default_nettype wire

//--- csr_index_cfg_queue.sv
// Configuration record output queue

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_cfg_settings.svh"

module csr_index_cfg_queue (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_index_generator,
    input  logic                                  record_valid,
    input  csr_index_cfg_pkg::csr_index_config_t  record,
    input  logic                                  config_pop,
    output logic                                  config_valid,
    output csr_index_cfg_pkg::csr_index_config_t  config_out,
    output logic                                  queue_full,
    output logic                                  queue_empty
);

    localparam int unsigned DEPTH = `CSR_CFG_QUEUE_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);

    csr_index_cfg_pkg::csr_index_config_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // A record arriving while full is dropped
    assign push = record_valid & ~queue_full;
    assign pop  = config_pop & ~queue_empty;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            config_valid <= 1'b0;
        end else begin
            config_valid <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= record;
        end
        if (pop) begin
            config_out <= mem[rd_ptr];
        end
    end

    assign queue_full  = (count == FULL_COUNT);
    assign queue_empty = (count == '0);

    a_no_push_when_full : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator) record_valid |-> !queue_full)
        else $error("Configuration record lost, queue full");

endmodule

`default_nettype wire

//--- csr_index_cfg_top.sv
// CSR index configuration capture top

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_cfg_settings.svh"

module csr_index_cfg_top #(
    parameter int unsigned WINDOW_INDEX = 1
) (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_index_generator,
    input  logic                                  response_valid,
    input  logic [`CSR_CFG_OFFSET_W-1:0]          response_offset,
    input  logic [`CSR_CFG_DATA_W-1:0]            response_data,
    input  logic                                  config_pop,
    output logic                                  config_valid,
    output csr_index_cfg_pkg::csr_index_config_t  config_out,
    output logic                                  queue_full,
    output logic                                  queue_empty
);

    // ---------------------------------------------------------
    // Stage links
    // ---------------------------------------------------------
    logic                                 word_valid;
    csr_index_cfg_pkg::response_word_t    word;
    logic                                 slot_valid;
    csr_index_cfg_pkg::slot_onehot_t      slot;
    logic [`CSR_CFG_DATA_W-1:0]           slot_data;
    logic                                 frame_done;
    logic                                 record_valid;
    csr_index_cfg_pkg::csr_index_config_t record;

    csr_index_cfg_window_filter #(
        .WINDOW_INDEX(WINDOW_INDEX)
    ) i_window_filter (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response_valid             (response_valid),
        .response_offset            (response_offset),
        .response_data              (response_data),
        .word_valid                 (word_valid),
        .word                       (word)
    );

    csr_index_cfg_word_tracker #(
        .WINDOW_INDEX(WINDOW_INDEX)
    ) i_word_tracker (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .word_valid                 (word_valid),
        .word                       (word),
        .slot_valid                 (slot_valid),
        .slot                       (slot),
        .slot_data                  (slot_data),
        .frame_done                 (frame_done)
    );

    csr_index_cfg_field_decoder i_field_decoder (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .slot_valid                 (slot_valid),
        .slot                       (slot),
        .slot_data                  (slot_data),
        .frame_done                 (frame_done),
        .record_valid               (record_valid),
        .record                     (record)
    );

    csr_index_cfg_queue i_queue (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .record_valid               (record_valid),
        .record                     (record),
        .config_pop                 (config_pop),
        .config_valid               (config_valid),
        .config_out                 (config_out),
        .queue_full                 (queue_full),
        .queue_empty                (queue_empty)
    );

endmodule

`default_nettype wire

//--- csr_index_cfg_tb.sv
// CSR index configuration testbench

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_cfg_settings.svh"

module csr_index_cfg_tb;

    localparam int unsigned SEQ        = `CSR_CFG_SEQ_WIDTH;
    localparam int unsigned OFF_W      = `CSR_CFG_OFFSET_W;
    localparam int unsigned BASE       = 16;
    localparam int unsigned WAIT_LIMIT = 50;

    // One table row per clock cycle
    typedef struct packed {
        logic                         valid;
        logic [`CSR_CFG_OFFSET_W-1:0] offset;
        logic [`CSR_CFG_DATA_W-1:0]   data;
        logic                         pop;
        logic                         check_flags;
        logic                         empty_exp;
    } stim_row_t;

    logic                                 ap_clk;
    logic                                 areset_csr_index_generator;
    logic                                 response_valid;
    logic [`CSR_CFG_OFFSET_W-1:0]         response_offset;
    logic [`CSR_CFG_DATA_W-1:0]           response_data;
    logic                                 config_pop;
    logic                                 config_valid;
    csr_index_cfg_pkg::csr_index_config_t config_out;
    logic                                 queue_full;
    logic                                 queue_empty;

    stim_row_t                            rows [$];
    csr_index_cfg_pkg::csr_index_config_t expected_q [$];
    logic [`CSR_CFG_DATA_W-1:0]           frame_words [SEQ];
    integer                               seed = 32'hf43d_17dd;

    csr_index_cfg_top #(
        .WINDOW_INDEX(1)
    ) i_csr_index_cfg_top (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response_valid             (response_valid),
        .response_offset            (response_offset),
        .response_data              (response_data),
        .config_pop                 (config_pop),
        .config_valid               (config_valid),
        .config_out                 (config_out),
        .queue_full                 (queue_full),
        .queue_empty                (queue_empty)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // ------------------------------------------------------------
    // Failure reporting and compares
    // ------------------------------------------------------------
    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_run($sformatf("Error at time %0t: %s is %b, expected %b",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_config(input csr_index_cfg_pkg::csr_index_config_t expected);
        if (config_out !== expected) begin
            stop_run($sformatf("Error at time %0t: config_out is %h, expected %h",
                               $time, config_out, expected));
        end
    endtask

    // Expected record decoded from the frame words
    function automatic csr_index_cfg_pkg::csr_index_config_t expected_record();
        csr_index_cfg_pkg::csr_index_config_t rec;
        rec = '0;
        rec.flags.increment     = frame_words[0][0];
        rec.flags.decrement     = frame_words[0][1];
        rec.flags.mode_sequence = frame_words[0][2];
        rec.flags.mode_buffer   = frame_words[0][3];
        rec.flags.mode_break    = frame_words[0][4];
        rec.flags.mode_parallel = frame_words[0][5];
        rec.index_start         = frame_words[1];
        rec.index_end           = frame_words[2];
        rec.stride              = frame_words[3];
        rec.granularity         = frame_words[4][`CSR_CFG_GRAN_W-1:0];
        rec.direction           = frame_words[4][`CSR_CFG_DATA_W-1];
        rec.id_channel          = frame_words[5][`CSR_CFG_CHANNEL_W-1:0];
        rec.id_buffer           = frame_words[6][`CSR_CFG_BUFFER_W-1:0];
        rec.array_size          = frame_words[7];
        rec.const_mask          = frame_words[8][3:0];
        rec.mode_cache          = frame_words[8][7:4];
        rec.const_value         = frame_words[9];
        rec.ops_mask            = frame_words[10][15:0];
        return rec;
    endfunction

    // Offsets just outside and far outside the window
    function automatic int unsigned stray_offset(input int unsigned i);
        case (i)
            1:       return 15;
            4:       return 32;
            7:       return 0;
            10:      return 16'hffff;
            default: return 47;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Table building
    // ------------------------------------------------------------
    task automatic add_row(input logic valid, input int unsigned offset,
                           input logic [`CSR_CFG_DATA_W-1:0] data, input logic pop,
                           input logic check_flags, input logic empty_exp);
        stim_row_t row;
        row.valid       = valid;
        row.offset      = OFF_W'(offset);
        row.data        = data;
        row.pop         = pop;
        row.check_flags = check_flags;
        row.empty_exp   = empty_exp;
        rows.push_back(row);
    endtask

    task automatic add_idle(input int unsigned cycles);
        repeat (cycles) add_row(1'b0, 0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic add_frame(input logic with_strays);
        for (int unsigned i = 0; i < SEQ; i++) begin
            frame_words[i] = $random(seed);
            add_row(1'b1, BASE + i, frame_words[i], 1'b0, 1'b0, 1'b0);
            if (with_strays && (i % 3 == 1)) begin
                add_row(1'b1, stray_offset(i), $random(seed), 1'b0, 1'b0, 1'b0);
            end
        end
        expected_q.push_back(expected_record());
    endtask

    task automatic build_table();
        // After reset
        repeat (3) add_row(1'b0, 0, '0, 1'b0, 1'b1, 1'b1);
        // Plain frame followed by one pop
        add_frame(1'b0);
        add_idle(6);
        add_row(1'b0, 0, '0, 1'b0, 1'b1, 1'b0);
        add_row(1'b0, 0, '0, 1'b1, 1'b0, 1'b0);
        add_row(1'b0, 0, '0, 1'b0, 1'b1, 1'b1);
        // Frame with out-of-window words mixed in
        add_frame(1'b1);
        add_idle(6);
        add_row(1'b0, 0, '0, 1'b1, 1'b0, 1'b0);
        add_row(1'b0, 0, '0, 1'b0, 1'b1, 1'b1);
        // Window words before any base word
        add_row(1'b1, 20, $random(seed), 1'b0, 1'b0, 1'b0);
        add_row(1'b1, 31, $random(seed), 1'b0, 1'b0, 1'b0);
        add_row(1'b1, 17, $random(seed), 1'b0, 1'b0, 1'b0);
        add_idle(6);
        add_row(1'b0, 0, '0, 1'b0, 1'b1, 1'b1);
        add_frame(1'b0);
        add_idle(6);
        add_row(1'b0, 0, '0, 1'b1, 1'b0, 1'b0);
        add_row(1'b0, 0, '0, 1'b0, 1'b1, 1'b1);
        // Three frames queued and then drained in order
        repeat (3) add_frame(1'b0);
        add_idle(6);
        add_row(1'b0, 0, '0, 1'b0, 1'b1, 1'b0);
        repeat (3) add_row(1'b0, 0, '0, 1'b1, 1'b0, 1'b0);
        add_row(1'b0, 0, '0, 1'b0, 1'b1, 1'b1);
    endtask

    // ------------------------------------------------------------
    // Row application
    // ------------------------------------------------------------
    task automatic apply_row(input stim_row_t row);
        int unsigned                          waited;
        csr_index_cfg_pkg::csr_index_config_t expected;
        @(posedge ap_clk);
        #1;
        response_valid  = row.valid;
        response_offset = row.offset;
        response_data   = row.data;
        config_pop      = row.pop;
        if (row.check_flags) begin
            check_bit("queue_empty", queue_empty, row.empty_exp);
            check_bit("queue_full", queue_full, 1'b0);
            check_bit("config_valid", config_valid, 1'b0);
        end
        if (row.pop) begin
            @(posedge ap_clk);
            #1;
            response_valid = 1'b0;
            config_pop     = 1'b0;
            waited         = 0;
            while (!config_valid) begin
                if (waited == WAIT_LIMIT) begin
                    stop_run("Timed out waiting for config_valid after a pop");
                end
                @(posedge ap_clk);
                #1;
                waited++;
            end
            if (expected_q.size() == 0) begin
                stop_run("A record came out of the queue with none expected");
            end
            expected = expected_q.pop_front();
            check_config(expected);
        end
    endtask

    initial begin
        areset_csr_index_generator = 1'b1;
        response_valid             = 1'b0;
        response_offset            = '0;
        response_data              = '0;
        config_pop                 = 1'b0;
        build_table();
        repeat (10) @(posedge ap_clk);
        #1;
        areset_csr_index_generator = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end
        if (expected_q.size() != 0) begin
            stop_run("Some expected records were never popped");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- csr_index_cfg.f
+incdir+.
csr_index_cfg_pkg.sv
csr_index_cfg_window_filter.sv
csr_index_cfg_word_tracker.sv
csr_index_cfg_field_decoder.sv
csr_index_cfg_queue.sv
csr_index_cfg_top.sv
csr_index_cfg_tb.sv
